//--- common/issue_pkg.sv
`default_nettype none

package issue_pkg;

    localparam int TAG_WIDTH     = 6;
    localparam int PAYLOAD_WIDTH = 16;
    localparam int RS_IDX_WIDTH  = 3;

    // Physical register tag
    typedef logic [TAG_WIDTH-1:0] tag_t;

    // Opcode and immediate, carried through issue untouched
    typedef logic [PAYLOAD_WIDTH-1:0] payload_t;

    // Slot index inside one bank, depths up to 8
    typedef logic [RS_IDX_WIDTH-1:0] rs_idx_t;

    typedef struct packed {
        logic     valid;
        tag_t     dest_tag;
        tag_t     src1_tag;
        logic     src1_ready;
        tag_t     src2_tag;
        logic     src2_ready;
        payload_t payload;
    } rs_entry_t;

    // One per functional unit slot, names the bank entry that was granted
    typedef struct packed {
        logic    valid;
        rs_idx_t idx;
    } issue_clear_t;

    // Entry may be handed to a functional unit
    function automatic logic entry_ready(rs_entry_t entry);
        return entry.valid && entry.src1_ready && entry.src2_ready;
    endfunction

    // Apply a result broadcast to both sources of an entry
    function automatic rs_entry_t wake_entry(rs_entry_t entry, logic bc_valid, tag_t bc_tag);
        rs_entry_t woken;
        woken = entry;
        if (bc_valid && entry.src1_tag == bc_tag) begin
            woken.src1_ready = 1'b1;
        end
        if (bc_valid && entry.src2_tag == bc_tag) begin
            woken.src2_ready = 1'b1;
        end
        return woken;
    endfunction

endpackage

`default_nettype wire

//--- rtl/reservation_station.sv
`default_nettype none

module reservation_station #(
    parameter int DEPTH  = 4,
    parameter int NUM_FU = 2
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 flush,
    input  logic                                 dispatch_valid,
    input  issue_pkg::rs_entry_t                 dispatch_entry,
    input  logic                                 broadcast_valid,
    input  issue_pkg::tag_t                      broadcast_tag,
    input  issue_pkg::issue_clear_t [NUM_FU-1:0] clear,
    output issue_pkg::rs_entry_t    [DEPTH-1:0]  entries,
    output logic                                 full
);

    import issue_pkg::*;

    rs_entry_t [DEPTH-1:0] entries_next;
    logic      [DEPTH-1:0] valid_next;
    logic                  slot_found;

    always_comb begin
        entries_next = entries;
        slot_found   = 1'b0;

        // Granted entries leave the bank, the rest see the broadcast
        for (int i = 0; i < DEPTH; i++) begin
            for (int f = 0; f < NUM_FU; f++) begin
                if (clear[f].valid && clear[f].idx == rs_idx_t'(i)) begin
                    entries_next[i].valid = 1'b0;
                end
            end
            entries_next[i] = wake_entry(entries_next[i], broadcast_valid, broadcast_tag);
        end

        // Dispatch takes the lowest slot that is free right now
        // A new entry also catches a broadcast of the same cycle
        for (int i = 0; i < DEPTH; i++) begin
            if (dispatch_valid && !slot_found && !entries[i].valid) begin
                entries_next[i] = wake_entry(dispatch_entry, broadcast_valid, broadcast_tag);
                entries_next[i].valid = 1'b1;
                slot_found = 1'b1;
            end
        end

        for (int i = 0; i < DEPTH; i++) begin
            valid_next[i] = entries_next[i].valid;
        end
    end

    // Only the valid bits are cleared, fields of empty slots are don't care
    always_ff @(posedge clock) begin
        entries <= entries_next;
        full    <= &valid_next;
        if (reset || flush) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
            full <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/allocator.sv
`default_nettype none

module allocator #(
    parameter int NUM_RESOURCES = 2,
    parameter int NUM_REQUESTS  = 4
) (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic [NUM_REQUESTS-1:0]                     req,
    // Release pulse per resource, the unit has taken its instruction
    input  logic [NUM_RESOURCES-1:0]                    done,
    output logic [NUM_REQUESTS-1:0][NUM_RESOURCES-1:0]  grant
);

    logic [NUM_RESOURCES-1:0] busy;
    logic [NUM_RESOURCES-1:0] granted;
    logic [NUM_REQUESTS-1:0]  taken;
    logic                     found;

    // Free resources in ascending order go to the lowest waiting requests
    always_comb begin
        grant = '0;
        taken = '0;
        found = 1'b0;
        for (int r = 0; r < NUM_RESOURCES; r++) begin
            found = 1'b0;
            if (!busy[r]) begin
                for (int q = 0; q < NUM_REQUESTS; q++) begin
                    if (req[q] && !taken[q] && !found) begin
                        grant[q][r] = 1'b1;
                        taken[q]    = 1'b1;
                        found       = 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        granted = '0;
        for (int q = 0; q < NUM_REQUESTS; q++) begin
            granted = granted | grant[q];
        end
    end

    // A fresh grant outlives a release of the same cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~done) | granted;
        end
    end

endmodule

`default_nettype wire

//--- issue/stage_issue.sv
`default_nettype none

module stage_issue #(
    parameter int ALU_RS_DEPTH  = 4,
    parameter int MULT_RS_DEPTH = 4,
    parameter int NUM_FU_ALU    = 2,
    parameter int NUM_FU_MULT   = 1
) (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        mispredict,
    input  issue_pkg::rs_entry_t    [ALU_RS_DEPTH-1:0]  alu_entries,
    input  issue_pkg::rs_entry_t    [MULT_RS_DEPTH-1:0] mult_entries,
    input  logic                    [NUM_FU_ALU-1:0]    alu_fu_done,
    input  logic                    [NUM_FU_MULT-1:0]   mult_fu_done,
    output issue_pkg::issue_clear_t [NUM_FU_ALU-1:0]    alu_clear,
    output issue_pkg::issue_clear_t [NUM_FU_MULT-1:0]   mult_clear,
    output issue_pkg::rs_entry_t    [NUM_FU_ALU-1:0]    issue_alu,
    output issue_pkg::rs_entry_t    [NUM_FU_MULT-1:0]   issue_mult,
    output logic                    [NUM_FU_ALU-1:0]    cdb_request_alu
);

    import issue_pkg::*;

    logic [ALU_RS_DEPTH-1:0]                   alu_ready;
    logic [MULT_RS_DEPTH-1:0]                  mult_ready;
    logic [ALU_RS_DEPTH-1:0][NUM_FU_ALU-1:0]   alu_grant;
    logic [MULT_RS_DEPTH-1:0][NUM_FU_MULT-1:0] mult_grant;

    rs_entry_t [NUM_FU_ALU-1:0]  alu_next;
    rs_entry_t [NUM_FU_MULT-1:0] mult_next;

    always_comb begin
        for (int i = 0; i < ALU_RS_DEPTH; i++) begin
            alu_ready[i] = entry_ready(alu_entries[i]);
        end
        for (int i = 0; i < MULT_RS_DEPTH; i++) begin
            mult_ready[i] = entry_ready(mult_entries[i]);
        end
    end

    // Mispredict drops every slot reservation
    allocator #(
        .NUM_RESOURCES (NUM_FU_ALU),
        .NUM_REQUESTS  (ALU_RS_DEPTH)
    ) alu_allocator (
        .clock (clock),
        .reset (reset | mispredict),
        .req   (alu_ready),
        .done  (alu_fu_done),
        .grant (alu_grant)
    );

    allocator #(
        .NUM_RESOURCES (NUM_FU_MULT),
        .NUM_REQUESTS  (MULT_RS_DEPTH)
    ) mult_allocator (
        .clock (clock),
        .reset (reset | mispredict),
        .req   (mult_ready),
        .done  (mult_fu_done),
        .grant (mult_grant)
    );

    // Grant matrix to per-slot clear index, and the next issue register
    always_comb begin
        alu_clear  = '0;
        mult_clear = '0;
        alu_next   = issue_alu;
        mult_next  = issue_mult;

        for (int f = 0; f < NUM_FU_ALU; f++) begin
            if (alu_fu_done[f]) begin
                alu_next[f].valid = 1'b0;
            end
        end
        for (int f = 0; f < NUM_FU_MULT; f++) begin
            if (mult_fu_done[f]) begin
                mult_next[f].valid = 1'b0;
            end
        end

        // Loaded after the done pulses, so a new grant wins
        for (int i = 0; i < ALU_RS_DEPTH; i++) begin
            for (int f = 0; f < NUM_FU_ALU; f++) begin
                if (alu_grant[i][f]) begin
                    alu_clear[f].valid = 1'b1;
                    alu_clear[f].idx   = rs_idx_t'(i);
                    alu_next[f]        = alu_entries[i];
                end
            end
        end
        for (int i = 0; i < MULT_RS_DEPTH; i++) begin
            for (int f = 0; f < NUM_FU_MULT; f++) begin
                if (mult_grant[i][f]) begin
                    mult_clear[f].valid = 1'b1;
                    mult_clear[f].idx   = rs_idx_t'(i);
                    mult_next[f]        = mult_entries[i];
                end
            end
        end
    end

    // Single-cycle ALU units ask for the result bus one cycle ahead
    always_comb begin
        for (int f = 0; f < NUM_FU_ALU; f++) begin
            cdb_request_alu[f] = alu_next[f].valid;
        end
    end

    always_ff @(posedge clock) begin
        issue_alu  <= alu_next;
        issue_mult <= mult_next;
        if (reset || mispredict) begin
            for (int f = 0; f < NUM_FU_ALU; f++) begin
                issue_alu[f].valid <= 1'b0;
            end
            for (int f = 0; f < NUM_FU_MULT; f++) begin
                issue_mult[f].valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/issue_top.sv
`default_nettype none

module issue_top #(
    parameter int ALU_RS_DEPTH  = 4,
    parameter int MULT_RS_DEPTH = 4,
    parameter int NUM_FU_ALU    = 2,
    parameter int NUM_FU_MULT   = 1
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    mispredict,
    input  logic                                    alu_dispatch_valid,
    input  issue_pkg::rs_entry_t                    alu_dispatch_entry,
    input  logic                                    mult_dispatch_valid,
    input  issue_pkg::rs_entry_t                    mult_dispatch_entry,
    input  logic                                    broadcast_valid,
    input  issue_pkg::tag_t                         broadcast_tag,
    input  logic                 [NUM_FU_ALU-1:0]   alu_fu_done,
    input  logic                 [NUM_FU_MULT-1:0]  mult_fu_done,
    output logic                                    alu_rs_full,
    output logic                                    mult_rs_full,
    output issue_pkg::rs_entry_t [NUM_FU_ALU-1:0]   issue_alu,
    output issue_pkg::rs_entry_t [NUM_FU_MULT-1:0]  issue_mult,
    output logic                 [NUM_FU_ALU-1:0]   cdb_request_alu
);

    import issue_pkg::*;

    rs_entry_t    [ALU_RS_DEPTH-1:0]  alu_entries;
    rs_entry_t    [MULT_RS_DEPTH-1:0] mult_entries;
    issue_clear_t [NUM_FU_ALU-1:0]    alu_clear;
    issue_clear_t [NUM_FU_MULT-1:0]   mult_clear;

    reservation_station #(
        .DEPTH  (ALU_RS_DEPTH),
        .NUM_FU (NUM_FU_ALU)
    ) alu_rs (
        .clock           (clock),
        .reset           (reset),
        .flush           (mispredict),
        .dispatch_valid  (alu_dispatch_valid),
        .dispatch_entry  (alu_dispatch_entry),
        .broadcast_valid (broadcast_valid),
        .broadcast_tag   (broadcast_tag),
        .clear           (alu_clear),
        .entries         (alu_entries),
        .full            (alu_rs_full)
    );

    reservation_station #(
        .DEPTH  (MULT_RS_DEPTH),
        .NUM_FU (NUM_FU_MULT)
    ) mult_rs (
        .clock           (clock),
        .reset           (reset),
        .flush           (mispredict),
        .dispatch_valid  (mult_dispatch_valid),
        .dispatch_entry  (mult_dispatch_entry),
        .broadcast_valid (broadcast_valid),
        .broadcast_tag   (broadcast_tag),
        .clear           (mult_clear),
        .entries         (mult_entries),
        .full            (mult_rs_full)
    );

    stage_issue #(
        .ALU_RS_DEPTH  (ALU_RS_DEPTH),
        .MULT_RS_DEPTH (MULT_RS_DEPTH),
        .NUM_FU_ALU    (NUM_FU_ALU),
        .NUM_FU_MULT   (NUM_FU_MULT)
    ) stage_issue_i (
        .clock           (clock),
        .reset           (reset),
        .mispredict      (mispredict),
        .alu_entries     (alu_entries),
        .mult_entries    (mult_entries),
        .alu_fu_done     (alu_fu_done),
        .mult_fu_done    (mult_fu_done),
        .alu_clear       (alu_clear),
        .mult_clear      (mult_clear),
        .issue_alu       (issue_alu),
        .issue_mult      (issue_mult),
        .cdb_request_alu (cdb_request_alu)
    );

endmodule

`default_nettype wire

//--- verif/issue_chk.sv
`default_nettype none

module issue_chk #(
    parameter int ALU_RS_DEPTH  = 4,
    parameter int MULT_RS_DEPTH = 4,
    parameter int NUM_FU_ALU    = 2,
    parameter int NUM_FU_MULT   = 1
) (
    input logic                                        clock,
    input logic                                        reset,
    input logic                                        mispredict,
    input logic [ALU_RS_DEPTH-1:0][NUM_FU_ALU-1:0]     alu_grant,
    input logic [MULT_RS_DEPTH-1:0][NUM_FU_MULT-1:0]   mult_grant,
    input logic [NUM_FU_ALU-1:0]                       alu_fu_done,
    input logic [NUM_FU_MULT-1:0]                      mult_fu_done,
    input issue_pkg::rs_entry_t [NUM_FU_ALU-1:0]       issue_alu,
    input issue_pkg::rs_entry_t [NUM_FU_MULT-1:0]      issue_mult,
    input logic [NUM_FU_ALU-1:0]                       cdb_request_alu
);

    logic grants_exclusive;
    logic loads_free;
    logic all_invalid;
    int   alu_col_count;
    int   mult_col_count;
    int   failures = 0;

    always_comb begin
        grants_exclusive = 1'b1;
        loads_free       = 1'b1;
        for (int i = 0; i < ALU_RS_DEPTH; i++) begin
            if (!$onehot0(alu_grant[i])) grants_exclusive = 1'b0;
        end
        for (int i = 0; i < MULT_RS_DEPTH; i++) begin
            if (!$onehot0(mult_grant[i])) grants_exclusive = 1'b0;
        end
        // A slot may only load when empty or released in the same cycle
        for (int f = 0; f < NUM_FU_ALU; f++) begin
            alu_col_count = 0;
            for (int i = 0; i < ALU_RS_DEPTH; i++) begin
                if (alu_grant[i][f]) begin
                    alu_col_count++;
                    if (issue_alu[f].valid && !alu_fu_done[f]) loads_free = 1'b0;
                end
            end
            if (alu_col_count > 1) grants_exclusive = 1'b0;
        end
        for (int f = 0; f < NUM_FU_MULT; f++) begin
            mult_col_count = 0;
            for (int i = 0; i < MULT_RS_DEPTH; i++) begin
                if (mult_grant[i][f]) begin
                    mult_col_count++;
                    if (issue_mult[f].valid && !mult_fu_done[f]) loads_free = 1'b0;
                end
            end
            if (mult_col_count > 1) grants_exclusive = 1'b0;
        end
        all_invalid = (cdb_request_alu == '0);
        for (int f = 0; f < NUM_FU_ALU; f++) begin
            if (issue_alu[f].valid) all_invalid = 1'b0;
        end
        for (int f = 0; f < NUM_FU_MULT; f++) begin
            if (issue_mult[f].valid) all_invalid = 1'b0;
        end
    end

    grant_exclusive_a: assert property (@(posedge clock) disable iff (reset) grants_exclusive)
        else begin
            $error("grant matrix has more than one bit in a row or column");
            failures++;
        end

    load_free_slot_a: assert property (@(posedge clock) disable iff (reset) loads_free)
        else begin
            $error("issue slot loaded while still busy");
            failures++;
        end

    flush_clears_a: assert property (@(posedge clock) disable iff (reset)
        mispredict |=> all_invalid)
        else begin
            $error("issue outputs still valid after mispredict");
            failures++;
        end

endmodule

bind stage_issue issue_chk #(
    .ALU_RS_DEPTH  (ALU_RS_DEPTH),
    .MULT_RS_DEPTH (MULT_RS_DEPTH),
    .NUM_FU_ALU    (NUM_FU_ALU),
    .NUM_FU_MULT   (NUM_FU_MULT)
) issue_chk_i (
    .clock           (clock),
    .reset           (reset),
    .mispredict      (mispredict),
    .alu_grant       (alu_grant),
    .mult_grant      (mult_grant),
    .alu_fu_done     (alu_fu_done),
    .mult_fu_done    (mult_fu_done),
    .issue_alu       (issue_alu),
    .issue_mult      (issue_mult),
    .cdb_request_alu (cdb_request_alu)
);

`default_nettype wire

//--- verif/issue_tb.sv
`default_nettype none

module issue_tb;

    import issue_pkg::*;

    localparam int DEPTH       = 4;
    localparam int NUM_FU_ALU  = 2;
    localparam int NUM_FU_MULT = 1;
    localparam int TIMEOUT     = 40;

    logic                              clock;
    logic                              reset;
    logic                              mispredict;
    logic                              alu_dispatch_valid;
    rs_entry_t                         alu_dispatch_entry;
    logic                              mult_dispatch_valid;
    rs_entry_t                         mult_dispatch_entry;
    logic                              broadcast_valid;
    tag_t                              broadcast_tag;
    logic      [NUM_FU_ALU-1:0]        alu_fu_done;
    logic      [NUM_FU_MULT-1:0]       mult_fu_done;
    logic                              alu_rs_full;
    logic                              mult_rs_full;
    rs_entry_t [NUM_FU_ALU-1:0]        issue_alu;
    rs_entry_t [NUM_FU_MULT-1:0]       issue_mult;
    logic      [NUM_FU_ALU-1:0]        cdb_request_alu;

    // Reference state, bank 0 is ALU and bank 1 is multiply
    rs_entry_t m_rs [2][DEPTH];
    rs_entry_t m_iss [2][2];
    logic      m_busy [2][2];
    logic      m_full [2];
    logic [NUM_FU_ALU-1:0] exp_cdb;
    logic [NUM_FU_ALU-1:0] seen_cdb;
    logic      checks_on;
    logic      cdb_checked;

    logic [31:0] rng_state;
    string       test_name;
    int          errors;
    int          test_start_errors;
    int          tests_run;
    int          tests_failed;

    issue_top #(
        .ALU_RS_DEPTH  (DEPTH),
        .MULT_RS_DEPTH (DEPTH),
        .NUM_FU_ALU    (NUM_FU_ALU),
        .NUM_FU_MULT   (NUM_FU_MULT)
    ) issue_top_i (
        .clock               (clock),
        .reset               (reset),
        .mispredict          (mispredict),
        .alu_dispatch_valid  (alu_dispatch_valid),
        .alu_dispatch_entry  (alu_dispatch_entry),
        .mult_dispatch_valid (mult_dispatch_valid),
        .mult_dispatch_entry (mult_dispatch_entry),
        .broadcast_valid     (broadcast_valid),
        .broadcast_tag       (broadcast_tag),
        .alu_fu_done         (alu_fu_done),
        .mult_fu_done        (mult_fu_done),
        .alu_rs_full         (alu_rs_full),
        .mult_rs_full        (mult_rs_full),
        .issue_alu           (issue_alu),
        .issue_mult          (issue_mult),
        .cdb_request_alu     (cdb_request_alu)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic rs_entry_t apply_broadcast(rs_entry_t e);
        rs_entry_t w;
        w = e;
        if (broadcast_valid && e.src1_tag == broadcast_tag) w.src1_ready = 1'b1;
        if (broadcast_valid && e.src2_tag == broadcast_tag) w.src2_ready = 1'b1;
        return w;
    endfunction

    // One clock of one bank, its allocator and its issue register
    function automatic void step_bank(int b, logic disp_valid, rs_entry_t disp,
                                      logic [1:0] done);
        rs_entry_t old_rs [DEPTH];
        logic      taken [DEPTH];
        logic      found;
        logic      placed;
        logic      all_valid;
        int        n;
        n = (b == 0) ? NUM_FU_ALU : NUM_FU_MULT;
        placed = 1'b0;
        all_valid = 1'b1;
        for (int i = 0; i < DEPTH; i++) begin
            old_rs[i] = m_rs[b][i];
            taken[i] = 1'b0;
        end
        for (int f = 0; f < n; f++) begin
            found = 1'b0;
            if (done[f]) m_iss[b][f].valid = 1'b0;
            if (!m_busy[b][f]) begin
                for (int i = 0; i < DEPTH; i++) begin
                    if (!found && !taken[i] && old_rs[i].valid && old_rs[i].src1_ready
                        && old_rs[i].src2_ready) begin
                        found = 1'b1;
                        taken[i] = 1'b1;
                        m_iss[b][f] = old_rs[i];
                        m_rs[b][i].valid = 1'b0;
                    end
                end
            end
            m_busy[b][f] = (m_busy[b][f] && !done[f]) || found;
            if (b == 0) exp_cdb[f] = m_iss[b][f].valid;
        end
        for (int i = 0; i < DEPTH; i++) begin
            m_rs[b][i] = apply_broadcast(m_rs[b][i]);
        end
        // Dispatch only into a slot that was empty before this edge
        for (int i = 0; i < DEPTH; i++) begin
            if (disp_valid && !placed && !old_rs[i].valid) begin
                m_rs[b][i] = apply_broadcast(disp);
                m_rs[b][i].valid = 1'b1;
                placed = 1'b1;
            end
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (!m_rs[b][i].valid) all_valid = 1'b0;
        end
        m_full[b] = all_valid;
    endfunction

    function automatic void model_step();
        if (reset || mispredict) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < DEPTH; i++) m_rs[b][i].valid = 1'b0;
                for (int f = 0; f < 2; f++) begin
                    m_iss[b][f].valid = 1'b0;
                    m_busy[b][f] = 1'b0;
                end
                m_full[b] = 1'b0;
            end
        end else begin
            step_bank(0, alu_dispatch_valid, alu_dispatch_entry, 2'(alu_fu_done));
            step_bank(1, mult_dispatch_valid, mult_dispatch_entry, {1'b0, mult_fu_done});
        end
    endfunction

    always @(posedge clock) begin
        seen_cdb = cdb_request_alu;
        cdb_checked = !(reset || mispredict);
        checks_on = !reset;
        model_step();
    end

    function automatic void check_entry(string what, rs_entry_t exp, rs_entry_t act);
        if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
            $display("[ERROR] %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endfunction

    function automatic void check_bits(string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endfunction

    // Registered outputs are stable at the falling edge
    always @(negedge clock) begin
        if (checks_on) begin
            for (int f = 0; f < NUM_FU_ALU; f++) begin
                check_entry($sformatf("issue_alu[%0d]", f), m_iss[0][f], issue_alu[f]);
            end
            for (int f = 0; f < NUM_FU_MULT; f++) begin
                check_entry($sformatf("issue_mult[%0d]", f), m_iss[1][f], issue_mult[f]);
            end
            check_bits("alu_rs_full", 32'(m_full[0]), 32'(alu_rs_full));
            check_bits("mult_rs_full", 32'(m_full[1]), 32'(mult_rs_full));
            if (cdb_checked) check_bits("cdb_request_alu", 32'(exp_cdb), 32'(seen_cdb));
        end
    end

    function automatic rs_entry_t make_entry(tag_t dest, tag_t s1, logic r1, tag_t s2,
                                             logic r2, payload_t p);
        rs_entry_t e;
        e.valid = 1'b1;
        e.dest_tag = dest;
        e.src1_tag = s1;
        e.src1_ready = r1;
        e.src2_tag = s2;
        e.src2_ready = r2;
        e.payload = p;
        return e;
    endfunction

    // Moves to the next falling edge with all strobes low
    task automatic next_cycle();
        @(negedge clock);
        alu_dispatch_valid = 1'b0;
        mult_dispatch_valid = 1'b0;
        broadcast_valid = 1'b0;
        alu_fu_done = '0;
        mult_fu_done = '0;
        mispredict = 1'b0;
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_start_errors = errors;
        tests_run++;
    endtask

    task automatic end_test();
        // The compare of the last falling edge is done by the next rising edge
        @(posedge clock);
        if (errors == test_start_errors) begin
            $display("%s: passed", test_name);
        end else begin
            $display("%s: failed with %0d errors", test_name, errors - test_start_errors);
            tests_failed++;
        end
    endtask

    task automatic wait_for_issue(int b, payload_t p, int slot);
        int  cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
            if (b == 0) seen = issue_alu[slot].valid && issue_alu[slot].payload == p;
            else seen = issue_mult[slot].valid && issue_mult[slot].payload == p;
        end
        if (!seen) begin
            $display("[ERROR] %s: payload %h never reached slot %0d of bank %0d",
                     test_name, p, slot, b);
            errors++;
        end
    endtask

    task automatic release_slots(logic [NUM_FU_ALU-1:0] alu, logic [NUM_FU_MULT-1:0] mult);
        next_cycle();
        alu_fu_done = alu;
        mult_fu_done = mult;
    endtask

    task automatic test_single_issue();
        rs_entry_t e;
        start_test("single_issue");
        e = make_entry(6'd1, 6'd2, 1'b1, 6'd3, 1'b1, 16'h1111);
        next_cycle();
        alu_dispatch_valid = 1'b1;
        alu_dispatch_entry = e;
        next_cycle();
        check_bits("cdb before issue", 32'd1, 32'(cdb_request_alu));
        next_cycle();
        check_entry("issued entry", e, issue_alu[0]);
        release_slots(2'b01, 1'b0);
        next_cycle();
        end_test();
    endtask

    task automatic test_wakeup();
        rs_entry_t e;
        start_test("wakeup");
        e = make_entry(6'd4, 6'd20, 1'b0, 6'd5, 1'b1, 16'h2222);
        next_cycle();
        alu_dispatch_valid = 1'b1;
        alu_dispatch_entry = e;
        repeat (3) next_cycle();
        check_bits("valid while pending", 32'd0, 32'(issue_alu[0].valid));
        broadcast_valid = 1'b1;
        broadcast_tag = 6'd20;
        next_cycle();
        check_bits("valid right after broadcast", 32'd0, 32'(issue_alu[0].valid));
        next_cycle();
        e.src1_ready = 1'b1;
        check_entry("woken entry", e, issue_alu[0]);
        release_slots(2'b01, 1'b0);
        next_cycle();
        end_test();
    endtask

    task automatic test_backpressure();
        start_test("backpressure");
        for (int k = 0; k < 3; k++) begin
            next_cycle();
            alu_dispatch_valid = 1'b1;
            alu_dispatch_entry = make_entry(6'(8 + k), 6'd1, 1'b1, 6'd2, 1'b1, 16'(16'h3000 + k));
            if (k < 2) begin
                mult_dispatch_valid = 1'b1;
                mult_dispatch_entry = make_entry(6'(12 + k), 6'd1, 1'b1, 6'd2, 1'b1,
                                                 16'(16'h4000 + k));
            end
        end
        repeat (4) next_cycle();
        check_bits("slot 0 payload", 32'h3000, 32'(issue_alu[0].payload));
        check_bits("slot 1 payload", 32'h3001, 32'(issue_alu[1].payload));
        check_bits("mult payload", 32'h4000, 32'(issue_mult[0].payload));
        release_slots(2'b01, 1'b1);
        wait_for_issue(0, 16'h3002, 0);
        wait_for_issue(1, 16'h4001, 0);
        release_slots(2'b11, 1'b1);
        next_cycle();
        end_test();
    endtask

    task automatic test_flush();
        start_test("flush");
        next_cycle();
        alu_dispatch_valid = 1'b1;
        alu_dispatch_entry = make_entry(6'd6, 6'd1, 1'b1, 6'd2, 1'b1, 16'h5000);
        mult_dispatch_valid = 1'b1;
        mult_dispatch_entry = make_entry(6'd7, 6'd31, 1'b0, 6'd2, 1'b1, 16'h5001);
        next_cycle();
        alu_dispatch_valid = 1'b1;
        alu_dispatch_entry = make_entry(6'd9, 6'd30, 1'b0, 6'd2, 1'b1, 16'h5002);
        repeat (2) next_cycle();
        mispredict = 1'b1;
        next_cycle();
        check_bits("alu valids", 32'd0, 32'({issue_alu[1].valid, issue_alu[0].valid}));
        check_bits("mult valid", 32'd0, 32'(issue_mult[0].valid));
        check_bits("cdb_request_alu", 32'd0, 32'(cdb_request_alu));
        check_bits("full flags", 32'd0, 32'({alu_rs_full, mult_rs_full}));
        broadcast_valid = 1'b1;
        broadcast_tag = 6'd30;
        next_cycle();
        broadcast_valid = 1'b1;
        broadcast_tag = 6'd31;
        for (int k = 0; k < 5; k++) begin
            next_cycle();
            check_bits("flushed entry issued", 32'd0,
                       32'({issue_alu[1].valid, issue_alu[0].valid, issue_mult[0].valid}));
        end
        end_test();
    endtask

    task automatic test_random();
        logic [31:0] r;
        start_test("random");
        for (int k = 0; k < 400; k++) begin
            next_cycle();
            r = next_random();
            if (!alu_rs_full && r[0]) begin
                alu_dispatch_valid = 1'b1;
                alu_dispatch_entry = make_entry(6'(r[14:12]), 6'(r[17:15]), r[18],
                                                6'(r[21:19]), r[22], 16'(16'h8000 + k));
            end
            r = next_random();
            if (!mult_rs_full && r[0]) begin
                mult_dispatch_valid = 1'b1;
                mult_dispatch_entry = make_entry(6'(r[14:12]), 6'(r[17:15]), r[18],
                                                 6'(r[21:19]), r[22], 16'(16'hc000 + k));
            end
            broadcast_valid = r[2];
            broadcast_tag = 6'(r[10:8]);
            alu_fu_done = r[5:4];
            mult_fu_done = r[6];
        end
        // Wake every tag in use and drain the slots
        for (int t = 0; t < 8; t++) begin
            next_cycle();
            broadcast_valid = 1'b1;
            broadcast_tag = 6'(t);
            alu_fu_done = '1;
            mult_fu_done = '1;
        end
        repeat (4) next_cycle();
        end_test();
    endtask

    initial begin
        rng_state = 32'h43b4_f11d;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        checks_on = 1'b0;
        cdb_checked = 1'b0;
        reset = 1'b1;
        mispredict = 1'b0;
        alu_dispatch_valid = 1'b0;
        alu_dispatch_entry = '0;
        mult_dispatch_valid = 1'b0;
        mult_dispatch_entry = '0;
        broadcast_valid = 1'b0;
        broadcast_tag = '0;
        alu_fu_done = '0;
        mult_fu_done = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        test_single_issue();
        test_wakeup();
        test_backpressure();
        test_flush();
        test_random();
        errors = errors + issue_top_i.stage_issue_i.issue_chk_i.failures;
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
common/issue_pkg.sv
rtl/reservation_station.sv
rtl/allocator.sv
issue/stage_issue.sv
rtl/issue_top.sv
verif/issue_chk.sv
verif/issue_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module issue_tb -Mdir obj_dir -o issue_tb
	./obj_dir/issue_tb | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
